// ==== design/nes_bus_pkg.sv ====
// nes bus package
// widths and types for the console memory port and the softcore bus,
// data-select constants and the softcore bridge state encoding

package nes_bus_pkg;

    ////////////////////////////////////////////////////////////////////
    // widths
    ////////////////////////////////////////////////////////////////////
    localparam int mem_addr_w     = 22;   // console memory address
    localparam int rv_addr_w      = 23;   // softcore byte address
    localparam int rv_half_addr_w = 20;   // half-word address on sdram port
    localparam int half_w         = 16;
    localparam int word_w         = 32;
    localparam int strb_w         = word_w / 8;
    localparam int ds_w           = half_w / 8;

    typedef logic [mem_addr_w-1:0] mem_addr_t;
    typedef logic [rv_addr_w-1:0]  rv_addr_t;
    typedef logic [half_w-1:0]     half_t;
    typedef logic [word_w-1:0]     word_t;
    typedef logic [strb_w-1:0]     strb_t;   // byte enables, 0 means read
    typedef logic [ds_w-1:0]       ds_t;     // data selects of one half

    ////////////////////////////////////////////////////////////////////
    // byte enable constants
    ////////////////////////////////////////////////////////////////////
    localparam strb_t strb_none = '0;     // no enables means a read
    localparam ds_t   ds_none   = '0;     // half not written
    localparam ds_t   ds_both   = '1;     // reads take both bytes

    // bridge states
    typedef enum logic [2:0] {
        idle_req0,      // idle, first request goes out here
        wait0_req1,     // wait first ack, then second request
        data0,          // low half on rv_dout
        wait1,          // wait second ack
        data1           // result back to softcore
    } rv_state_t;

endpackage

// ==== design/nes_console_pkg.sv ====
// nes console package
// joypad width, mapper numbers with expansion audio and the
// mapper flag word as the loader hands it over

package nes_console_pkg;

    ////////////////////////////////////////////////////////////////////
    // joypads
    ////////////////////////////////////////////////////////////////////
    localparam int pad_w = 8;              // A B select start up dn lt rt

    typedef logic [pad_w-1:0] pad_t;

    ////////////////////////////////////////////////////////////////////
    // mapper flags
    ////////////////////////////////////////////////////////////////////
    localparam int flags_w     = 64;
    localparam int mapper_id_w = 8;

    // mappers with extra sound hardware on the cart
    localparam logic [mapper_id_w-1:0] mapper_vrc6a = 8'd24;
    localparam logic [mapper_id_w-1:0] mapper_vrc6b = 8'd26;
    localparam logic [mapper_id_w-1:0] mapper_n163  = 8'd19;

    // raw word from the rom parser, or split into fields
    typedef union packed {
        logic [flags_w-1:0] raw;
        struct packed {
            logic [flags_w-mapper_id_w-1:0] upper;      // mirroring, prg/chr sizes etc
            logic [mapper_id_w-1:0]         mapper_id;  // low byte
        } f;
    } mapper_flags_u;

endpackage

// ==== design/rv_half_if.sv ====
// softcore half request interface
// one 16-bit half request from the bridge sequencer to the port packer

`timescale 1ns/1ps

interface rv_half_if import nes_bus_pkg::*; ();

    logic word;         // 1 = upper half
    ds_t  ds;           // data selects for this half
    logic we;           // write access
    logic req;          // toggle request
    logic capture_lo;   // latch low half of read data

    modport seq (
        output word, ds, we, req, capture_lo
    );

    modport port (
        input word, ds, we, req, capture_lo
    );

endinterface

// ==== design/rv_half_seq.sv ====
// softcore bridge sequencer
// splits a 32-bit softcore access into one or two toggle requests
// on the 16-bit sdram port, skipping halves with no byte enables

`timescale 1ns/1ps

module rv_half_seq import nes_bus_pkg::*; (
    input  logic   clk,
    input  logic   sys_resetn,
    input  logic   rv_valid,
    input  strb_t  rv_wstrb,
    input  logic   rv_req_ack,
    output logic   rv_ready,
    rv_half_if.seq half
);

    rv_state_t state;
    logic      valid_r;     // previous valid level
    logic      new_pend;    // edge seen while busy
    logic      req_q;
    logic      word_q;
    ds_t       ds_q;

    logic      new_edge;
    logic      is_write;
    logic      ack_match;
    logic      start;
    ds_t       ds_lo;
    ds_t       ds_hi;

    assign new_edge  = rv_valid & ~valid_r;
    assign is_write  = rv_wstrb != strb_none;   // wstrb stable until ready
    assign ack_match = req_q == rv_req_ack;     // toggle handshake done
    assign start     = new_pend | new_edge;
    assign ds_lo     = rv_wstrb[1:0];
    assign ds_hi     = rv_wstrb[3:2];

    assign half.word       = word_q;
    assign half.ds         = ds_q;
    assign half.we         = is_write;
    assign half.req        = req_q;
    assign half.capture_lo = state == data0;    // cycle after first match

    ////////////////////////////////////////////////////////////////////
    // request sequencing
    ////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!sys_resetn) begin
            state    <= idle_req0;
            rv_ready <= 1'b0;
            valid_r  <= 1'b0;
            new_pend <= 1'b0;
            req_q    <= 1'b0;
            word_q   <= 1'b0;
            ds_q     <= ds_both;
        end else begin
            rv_ready <= 1'b0;       // one cycle pulse
            valid_r  <= rv_valid;
            if (new_edge)
                new_pend <= 1'b1;   // remembered until idle

            case (state)
                idle_req0: if (start) begin
                    new_pend <= 1'b0;
                    req_q    <= ~req_q;
                    if (is_write && ds_lo == ds_none) begin
                        // upper half only
                        word_q <= 1'b1;
                        ds_q   <= ds_hi;
                        state  <= wait1;
                    end else begin
                        word_q <= 1'b0;
                        ds_q   <= is_write ? ds_lo : ds_both;
                        state  <= wait0_req1;
                    end
                end

                wait0_req1: if (ack_match) begin
                    if (!is_write) begin
                        req_q  <= ~req_q;       // upper half read
                        word_q <= 1'b1;
                        ds_q   <= ds_both;
                        state  <= data0;
                    end else if (ds_hi == ds_none) begin
                        rv_ready <= 1'b1;       // lower only, done
                        state    <= idle_req0;
                    end else begin
                        req_q  <= ~req_q;
                        word_q <= 1'b1;
                        ds_q   <= ds_hi;
                        state  <= wait1;
                    end
                end

                data0: state <= wait1;          // port packer grabs low half

                wait1: if (ack_match) begin
                    if (is_write) begin
                        rv_ready <= 1'b1;
                        state    <= idle_req0;
                    end else begin
                        state <= data1;         // upper half valid next
                    end
                end

                data1: begin
                    rv_ready <= 1'b1;
                    state    <= idle_req0;
                end

                default: state <= idle_req0;
            endcase
        end
    end

endmodule

// ==== design/rv_half_port.sv ====
// softcore bridge port packer
// builds the half address and write data for the sdram port and
// puts the two read halves back together

`timescale 1ns/1ps

module rv_half_port import nes_bus_pkg::*; (
    input  logic                      clk,
    input  rv_addr_t                  rv_addr,
    input  word_t                     rv_wdata,
    input  half_t                     rv_dout,
    rv_half_if.port                   half,
    output logic [rv_half_addr_w-1:0] sdram_rv_addr,
    output half_t                     sdram_rv_din,
    output ds_t                       sdram_rv_ds,
    output logic                      sdram_rv_we,
    output logic                      sdram_rv_req,
    output word_t                     rv_rdata
);

    half_t dout_lo;     // low half of a read

    ////////////////////////////////////////////////////////////////////
    // request side
    ////////////////////////////////////////////////////////////////////

    // word address from the byte address, half select at bit 0
    assign sdram_rv_addr = {rv_addr[rv_half_addr_w:2], half.word};

    always_comb begin
        if (half.word)
            sdram_rv_din = rv_wdata[word_w-1:half_w];
        else
            sdram_rv_din = rv_wdata[half_w-1:0];
    end

    assign sdram_rv_ds  = half.ds;
    assign sdram_rv_we  = half.we;
    assign sdram_rv_req = half.req;

    ////////////////////////////////////////////////////////////////////
    // read side
    ////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (half.capture_lo)
            dout_lo <= rv_dout;
    end

    // upper half still live on rv_dout when ready pulses
    assign rv_rdata = {rv_dout, dout_lo};

endmodule

// ==== design/cart_load_ctrl.sv ====
// cartridge load controller
// stretches loader writes and lets them take over the cpu memory port,
// latches mapper flags, and sequences console reset and clkref

`timescale 1ns/1ps

module cart_load_ctrl import nes_bus_pkg::*, nes_console_pkg::*; (
    input  logic          clk,
    input  logic          sys_resetn,
    input  logic          loading,
    input  logic          loader_write,
    input  mem_addr_t     loader_addr,
    input  logic [7:0]    loader_data,
    input  logic          loader_done,
    input  mapper_flags_u loader_flags,
    input  mem_addr_t     cpu_addr,
    input  logic          cpu_read,
    input  logic          cpu_write,
    input  logic [7:0]    cpu_dout,
    output mem_addr_t     mem_addr,
    output logic          mem_we,
    output logic [7:0]    mem_din,
    output logic          mem_oe,
    output mapper_flags_u mapper_flags,
    output logic          ext_audio,
    output logic          reset_nes,
    output logic          clkref,
    output logic          loader_reset
);

    logic       loading_r;
    logic       write_r;        // loader write one cycle back
    logic       write_mem;      // two cycle write
    mem_addr_t  addr_mem;
    logic [7:0] data_mem;

    ////////////////////////////////////////////////////////////////////
    // loader write path
    ////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!sys_resetn) begin
            write_r      <= 1'b0;
            write_mem    <= 1'b0;
            mapper_flags <= '0;
        end else begin
            write_r   <= loader_write;
            write_mem <= loader_write | write_r;    // stretch to 2
            if (loader_done)
                mapper_flags <= loader_flags;
        end
    end

    always_ff @(posedge clk) begin
        if (loader_write) begin
            addr_mem <= loader_addr;
            data_mem <= loader_data;
        end
    end

    // loader owns the cpu port while loading
    assign mem_addr = loading ? addr_mem : cpu_addr;
    assign mem_din  = loading ? data_mem : cpu_dout;
    assign mem_oe   = ~loading & cpu_read;      // no cpu reads mid load
    assign mem_we   = write_mem | cpu_write;

    // vrc6 and namco 163 carts
    assign ext_audio = (mapper_flags.f.mapper_id == mapper_vrc6a) |
                       (mapper_flags.f.mapper_id == mapper_vrc6b) |
                       (mapper_flags.f.mapper_id == mapper_n163);

    ////////////////////////////////////////////////////////////////////
    // console reset and reference clock
    ////////////////////////////////////////////////////////////////////
    assign loader_reset = loading & ~loading_r;     // rising edge of loading

    always_ff @(posedge clk) begin
        if (!sys_resetn) begin
            loading_r <= 1'b0;
            reset_nes <= 1'b1;
            clkref    <= 1'b0;
        end else begin
            loading_r <= loading;
            clkref    <= ~clkref;
            if (~loading & loading_r) begin
                reset_nes <= 1'b0;      // load finished, start console
                clkref    <= 1'b1;      // realign phase
            end else if (loading & ~loading_r) begin
                reset_nes <= 1'b1;
            end
        end
    end

endmodule

// ==== design/joypad_serial.sv ====
// joypad serialiser
// parallel load of the buttons on strobe, then one bit out per
// falling edge of the pad clock, ones after the last button

`timescale 1ns/1ps

module joypad_serial import nes_console_pkg::*; (
    input  logic clk,
    input  logic strobe,
    input  logic pad_clk,
    input  pad_t buttons,
    output logic data
);

    pad_t bits;         // shift register, bit 0 goes out
    logic pad_clk_r;    // previous pad clock
    logic pad_fall;

    assign pad_fall = ~pad_clk & pad_clk_r;

    always_ff @(posedge clk) begin
        pad_clk_r <= pad_clk;
        if (strobe)
            bits <= buttons;    // A first
        if (pad_fall)
            bits <= {1'b1, bits[pad_w-1:1]};    // open bus reads as 1
    end

    assign data = bits[0];

endmodule

// ==== design/nes_glue_top.sv ====
// nes glue top level
// softcore to sdram bridge, cart load path, console reset and
// joypad serialisers on flat ports

`timescale 1ns/1ps

module nes_glue_top import nes_bus_pkg::*, nes_console_pkg::*; (
    input  logic                      clk,
    input  logic                      sys_resetn,
    // softcore bus
    input  logic                      rv_valid,
    output logic                      rv_ready,
    input  rv_addr_t                  rv_addr,
    input  word_t                     rv_wdata,
    input  strb_t                     rv_wstrb,
    output word_t                     rv_rdata,
    // sdram softcore port
    output logic [rv_half_addr_w-1:0] sdram_rv_addr,
    output half_t                     sdram_rv_din,
    output ds_t                       sdram_rv_ds,
    output logic                      sdram_rv_we,
    output logic                      sdram_rv_req,
    input  logic                      rv_req_ack,
    input  half_t                     rv_dout,
    // loader
    input  logic                      loading,
    input  logic                      loader_write,
    input  mem_addr_t                 loader_addr,
    input  logic [7:0]                loader_data,
    input  logic                      loader_done,
    input  logic [flags_w-1:0]        loader_flags,
    output logic                      loader_reset,
    // cpu memory port
    input  mem_addr_t                 cpu_addr,
    input  logic                      cpu_read,
    input  logic                      cpu_write,
    input  logic [7:0]                cpu_dout,
    output mem_addr_t                 mem_addr,
    output logic                      mem_we,
    output logic [7:0]                mem_din,
    output logic                      mem_oe,
    // console control
    output logic [flags_w-1:0]        mapper_flags,
    output logic                      ext_audio,
    output logic                      reset_nes,
    output logic                      clkref,
    // joypads
    input  logic                      joypad_strobe,
    input  logic [1:0]                joypad_clock,
    input  pad_t                      joy1_btns,
    input  pad_t                      joy2_btns,
    output logic                      joypad1_data,
    output logic                      joypad2_data
);

    ////////////////////////////////////////////////////////////////////
    // softcore bridge
    ////////////////////////////////////////////////////////////////////
    rv_half_if half_if ();

    rv_half_seq seq_i (
        .clk(clk), .sys_resetn(sys_resetn), .rv_valid(rv_valid),
        .rv_wstrb(rv_wstrb), .rv_req_ack(rv_req_ack), .rv_ready(rv_ready),
        .half(half_if)
    );

    rv_half_port port_i (
        .clk(clk), .rv_addr(rv_addr), .rv_wdata(rv_wdata), .rv_dout(rv_dout),
        .half(half_if), .sdram_rv_addr(sdram_rv_addr), .sdram_rv_din(sdram_rv_din),
        .sdram_rv_ds(sdram_rv_ds), .sdram_rv_we(sdram_rv_we),
        .sdram_rv_req(sdram_rv_req), .rv_rdata(rv_rdata)
    );

    ////////////////////////////////////////////////////////////////////
    // cart load and console control
    ////////////////////////////////////////////////////////////////////
    cart_load_ctrl cart_i (
        .clk(clk), .sys_resetn(sys_resetn), .loading(loading),
        .loader_write(loader_write), .loader_addr(loader_addr),
        .loader_data(loader_data), .loader_done(loader_done),
        .loader_flags(loader_flags), .cpu_addr(cpu_addr), .cpu_read(cpu_read),
        .cpu_write(cpu_write), .cpu_dout(cpu_dout), .mem_addr(mem_addr),
        .mem_we(mem_we), .mem_din(mem_din), .mem_oe(mem_oe),
        .mapper_flags(mapper_flags), .ext_audio(ext_audio),
        .reset_nes(reset_nes), .clkref(clkref), .loader_reset(loader_reset)
    );

    // one serialiser per controller port
    joypad_serial joy1_i (
        .clk(clk), .strobe(joypad_strobe), .pad_clk(joypad_clock[0]),
        .buttons(joy1_btns), .data(joypad1_data)
    );

    joypad_serial joy2_i (
        .clk(clk), .strobe(joypad_strobe), .pad_clk(joypad_clock[1]),
        .buttons(joy2_btns), .data(joypad2_data)
    );

endmodule

// ==== sim/nes_glue_ref.svh ====
// nes glue reference model
// expected results for the softcore bridge, joypads and mapper decode

`ifndef NES_GLUE_REF_SVH
`define NES_GLUE_REF_SVH

// sdram contents before any write, spread over all 20 address bits
function automatic logic [15:0] fill_half(input logic [19:0] a);
    return a[15:0] ^ {a[19:16], a[19:16], a[19:16], a[19:16]} ^ 16'h5a3c;
endfunction

// word after a write, byte by byte by enable
function automatic logic [31:0] merge_word(input logic [31:0] old_w,
                                           input logic [31:0] new_w,
                                           input logic [3:0]  strb);
    logic [31:0] res;
    int          b;
    res = old_w;
    for (b = 0; b < 4; b++) begin
        if (strb[b])
            res[8*b +: 8] = new_w[8*b +: 8];
    end
    return res;
endfunction

// half requests per access, a half with no enables is skipped
function automatic int req_toggles(input logic [3:0] strb);
    if (strb == 4'b0000)
        return 2;                   // read, both halves
    if (strb[1:0] == 2'b00 || strb[3:2] == 2'b00)
        return 1;
    return 2;
endfunction

// serial joypad bit n after strobe, A first then ones
function automatic logic pad_bit(input logic [7:0] btns, input int n);
    if (n < 8)
        return btns[n];
    return 1'b1;
endfunction

// vrc6a, vrc6b and namco 163
function automatic logic has_ext_audio(input logic [7:0] id);
    return id == 8'd19 || id == 8'd24 || id == 8'd26;
endfunction

`endif

// ==== sim/nes_glue_tb.sv ====
// nes glue testbench
// runs the softcore bridge against an sdram half-port model, then the
// cart load path, mapper flags, console reset sequencing and joypads

`timescale 1ns/1ps

module nes_glue_tb import nes_bus_pkg::*, nes_console_pkg::*; ();

    `include "nes_glue_ref.svh"

    logic                      clk;
    logic                      sys_resetn;
    logic                      rv_valid;
    logic                      rv_ready;
    rv_addr_t                  rv_addr;
    word_t                     rv_wdata;
    strb_t                     rv_wstrb;
    word_t                     rv_rdata;
    logic [rv_half_addr_w-1:0] sdram_rv_addr;
    half_t                     sdram_rv_din;
    ds_t                       sdram_rv_ds;
    logic                      sdram_rv_we;
    logic                      sdram_rv_req;
    logic                      rv_req_ack;
    half_t                     rv_dout;
    logic                      loading;
    logic                      loader_write;
    mem_addr_t                 loader_addr;
    logic [7:0]                loader_data;
    logic                      loader_done;
    logic [63:0]               loader_flags;
    logic                      loader_reset;
    mem_addr_t                 cpu_addr;
    logic                      cpu_read;
    logic                      cpu_write;
    logic [7:0]                cpu_dout;
    mem_addr_t                 mem_addr;
    logic                      mem_we;
    logic [7:0]                mem_din;
    logic                      mem_oe;
    logic [63:0]               mapper_flags;
    logic                      ext_audio;
    logic                      reset_nes;
    logic                      clkref;
    logic                      joypad_strobe;
    logic [1:0]                joypad_clock;
    pad_t                      joy1_btns;
    pad_t                      joy2_btns;
    logic                      joypad1_data;
    logic                      joypad2_data;

    integer seed = 32'hd8e249f4;
    int     errors = 0;
    int     tests = 0;
    int     test_base = 0;      // errors at start of current test
    half_t  sdram_mem [int];    // written halves only
    word_t  shadow [int];       // expected words by word address

    nes_glue_top dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;  // 4 ns
    end

    //////////////////////////////////////////////////////////////////////
    // sdram half-port model
    //////////////////////////////////////////////////////////////////////
    initial begin : sdram_model
        int    delay;
        int    a;
        half_t cur;
        rv_req_ack = 1'b0;
        rv_dout    = '0;
        forever begin
            @(negedge clk);
            if (sys_resetn && sdram_rv_req !== rv_req_ack) begin
                delay = {$random(seed)} % 4;
                repeat (delay + 1) @(negedge clk);     // one cycle access minimum
                a   = sdram_rv_addr;
                cur = sdram_mem.exists(a) ? sdram_mem[a] : fill_half(sdram_rv_addr);
                if (sdram_rv_we) begin
                    if (sdram_rv_ds[0]) cur[7:0]  = sdram_rv_din[7:0];
                    if (sdram_rv_ds[1]) cur[15:8] = sdram_rv_din[15:8];
                    sdram_mem[a] = cur;
                end
                rv_dout    <= cur;
                rv_req_ack <= sdram_rv_req;     // ack after data
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////////////////////////
    task automatic note_mismatch(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
        $display("mismatch %s: got %h expected %h", name, got, exp);
        errors++;
    endtask

    task automatic note_error(input string what);
        $display("error: %s", what);
        errors++;
    endtask

    task automatic timed_out(input string what);
        $display("timeout while waiting for %s", what);
        $display("** FAIL **");
        $finish;
    endtask

    task automatic end_test(input string name);
        $display("test %-10s done, %0d failed checks", name, errors - test_base);
        tests++;
        test_base = errors;
    endtask

    // one softcore access, called on a falling edge
    task automatic bus_access(input rv_addr_t addr, input word_t wdata, input strb_t strb,
                              output word_t rdata, output int toggles);
        int   wait_cnt;
        logic req_prev;
        logic seen;
        rv_addr  = addr;
        rv_wdata = wdata;
        rv_wstrb = strb;
        rv_valid = 1'b1;
        req_prev = sdram_rv_req;
        toggles  = 0;
        wait_cnt = 0;
        seen     = 1'b0;
        while (!seen) begin
            @(negedge clk);
            if (sdram_rv_req !== req_prev)
                toggles++;
            req_prev = sdram_rv_req;
            if (rv_ready)
                seen = 1'b1;
            else if (++wait_cnt > 40)
                timed_out("rv_ready");
        end
        rdata = rv_rdata;
        if (sdram_rv_req !== rv_req_ack)
            note_error("rv_ready came before the last ack match");
        rv_valid = 1'b0;
        repeat (2) begin                        // no second ready, no late request
            @(negedge clk);
            if (rv_ready)
                note_error("rv_ready pulsed twice for one access");
            if (sdram_rv_req !== req_prev)
                toggles++;
            req_prev = sdram_rv_req;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // stimulus and checking
    //////////////////////////////////////////////////////////////////////
    initial begin : stim_check
        rv_addr_t    addr;
        word_t       wdata;
        word_t       rdata;
        word_t       old_w;
        word_t       exp_w;
        strb_t       strb;
        int          toggles;
        int          wa;
        int          n1;
        int          n2;
        int          steps;
        logic        prev;
        logic [1:0]  sel;
        logic [7:0]  j1;
        logic [7:0]  j2;
        logic [7:0]  ids [6];
        logic [63:0] flags;
        mem_addr_t   laddr;
        logic [7:0]  ldata;

        sys_resetn    = 1'b0;
        rv_valid      = 1'b0;
        rv_addr       = '0;
        rv_wdata      = '0;
        rv_wstrb      = '0;
        loading       = 1'b0;
        loader_write  = 1'b0;
        loader_addr   = '0;
        loader_data   = '0;
        loader_done   = 1'b0;
        loader_flags  = '0;
        cpu_addr      = '0;
        cpu_read      = 1'b0;
        cpu_write     = 1'b0;
        cpu_dout      = '0;
        joypad_strobe = 1'b0;
        joypad_clock  = 2'b00;
        joy1_btns     = '0;
        joy2_btns     = '0;
        ids           = '{8'd19, 8'd24, 8'd26, 8'd18, 8'd25, 8'd27};

        repeat (3) @(negedge clk);
        sys_resetn = 1'b1;
        @(negedge clk);
        if (rv_ready !== 1'b0) note_mismatch("rv_ready", rv_ready, 0);
        if (reset_nes !== 1'b1) note_mismatch("reset_nes", reset_nes, 1);
        if (mem_we !== 1'b0) note_mismatch("mem_we", mem_we, 0);
        end_test("reset");

        // masked writes, each read back; few words so they get rewritten
        for (int i = 0; i < 24; i++) begin
            addr  = rv_addr_t'($random(seed)) & 23'h10001c;
            wdata = $random(seed);
            case (i)
                0: strb = 4'b1100;      // upper only
                1: strb = 4'b0011;      // lower only
                2: strb = 4'b0100;
                3: strb = 4'b1111;
                default: begin
                    strb = $random(seed);
                    if (strb == 4'b0000) strb = 4'b1000;
                end
            endcase
            wa    = addr[20:2];
            old_w = shadow.exists(wa) ? shadow[wa]
                  : {fill_half({addr[20:2], 1'b1}), fill_half({addr[20:2], 1'b0})};
            exp_w = merge_word(old_w, wdata, strb);
            shadow[wa] = exp_w;
            bus_access(addr, wdata, strb, rdata, toggles);
            if (toggles != req_toggles(strb))
                note_mismatch("write req toggles", toggles, req_toggles(strb));
            bus_access(addr, $random(seed), 4'b0000, rdata, toggles);
            if (toggles != 2) note_mismatch("read req toggles", toggles, 2);
            if (rdata !== exp_w) note_mismatch("rv_rdata", rdata, exp_w);
        end
        end_test("bridge");

        // loader writes own the memory port, cpu reads blocked
        loading   = 1'b1;
        cpu_read  = 1'b1;
        cpu_addr  = $random(seed);
        cpu_dout  = $random(seed);
        repeat (2) @(negedge clk);
        for (int i = 0; i < 6; i++) begin
            laddr = $random(seed);
            ldata = $random(seed);
            if (mem_we !== 1'b0) note_mismatch("mem_we", mem_we, 0);
            loader_write = 1'b1;
            loader_addr  = laddr;
            loader_data  = ldata;
            for (int k = 1; k <= 4; k++) begin
                @(negedge clk);
                loader_write = 1'b0;
                loader_addr  = $random(seed);   // latched copy must hold
                loader_data  = $random(seed);
                if (mem_we !== (k <= 2)) note_mismatch("mem_we", mem_we, k <= 2);
                if (k <= 2 && mem_addr !== laddr) note_mismatch("mem_addr", mem_addr, laddr);
                if (k <= 2 && mem_din !== ldata) note_mismatch("mem_din", mem_din, ldata);
                if (mem_oe !== 1'b0) note_mismatch("mem_oe", mem_oe, 0);
            end
        end
        end_test("loader");

        // mapper flags latched on done, audio decode over the id
        for (int i = 0; i < 20; i++) begin
            flags = {$random(seed), $random(seed)};
            if (i < 6) flags[7:0] = ids[i];     // audio ids and neighbours
            loader_flags = flags;
            loader_done  = 1'b1;
            @(negedge clk);
            loader_done  = 1'b0;
            loader_flags = '0;
            if (mapper_flags !== flags) note_mismatch("mapper_flags", mapper_flags, flags);
            if (ext_audio !== has_ext_audio(flags[7:0]))
                note_mismatch("ext_audio", ext_audio, has_ext_audio(flags[7:0]));
        end
        end_test("flags");

        // end of load releases the console and realigns clkref
        if (reset_nes !== 1'b1) note_mismatch("reset_nes", reset_nes, 1);
        steps = 0;
        while (clkref !== 1'b1) begin       // free running it would drop next
            if (++steps > 2) timed_out("clkref high");
            @(negedge clk);
        end
        loading = 1'b0;
        @(negedge clk);
        if (reset_nes !== 1'b0) note_mismatch("reset_nes", reset_nes, 0);
        if (clkref !== 1'b1) note_mismatch("clkref", clkref, 1);
        prev = clkref;
        repeat (6) begin
            @(negedge clk);
            if (clkref !== ~prev) note_mismatch("clkref", clkref, ~prev);
            prev = clkref;
        end
        // cpu values straight through
        for (int i = 0; i < 6; i++) begin
            cpu_addr  = $random(seed);
            cpu_dout  = $random(seed);
            cpu_read  = $random(seed);
            cpu_write = $random(seed);
            @(negedge clk);
            if (mem_addr !== cpu_addr) note_mismatch("mem_addr", mem_addr, cpu_addr);
            if (mem_din !== cpu_dout) note_mismatch("mem_din", mem_din, cpu_dout);
            if (mem_oe !== cpu_read) note_mismatch("mem_oe", mem_oe, cpu_read);
            if (mem_we !== cpu_write) note_mismatch("mem_we", mem_we, cpu_write);
        end
        cpu_write = 1'b0;
        end_test("load_end");

        // start of a new load
        if (reset_nes !== 1'b0) note_mismatch("reset_nes", reset_nes, 0);
        loading = 1'b1;
        #1;
        if (loader_reset !== 1'b1) note_mismatch("loader_reset", loader_reset, 1);
        @(negedge clk);
        if (reset_nes !== 1'b1) note_mismatch("reset_nes", reset_nes, 1);
        if (loader_reset !== 1'b0) note_mismatch("loader_reset", loader_reset, 0);
        loading = 1'b0;
        @(negedge clk);
        end_test("load_start");

        // joypads, strobe then independent pad clocks
        j1 = $random(seed);
        j2 = $random(seed);
        joy1_btns     = j1;
        joy2_btns     = j2;
        joypad_strobe = 1'b1;
        @(negedge clk);
        joypad_strobe = 1'b0;
        joy1_btns     = $random(seed);
        joy2_btns     = $random(seed);
        n1    = 0;
        n2    = 0;
        steps = 0;
        if (joypad1_data !== pad_bit(j1, 0)) note_mismatch("joypad1_data", joypad1_data, j1[0]);
        if (joypad2_data !== pad_bit(j2, 0)) note_mismatch("joypad2_data", joypad2_data, j2[0]);
        while (n1 < 11 || n2 < 11) begin
            if (++steps > 80) timed_out("joypad shifts");
            sel          = $random(seed);
            joypad_clock = sel;
            @(negedge clk);
            joypad_clock = 2'b00;
            @(negedge clk);                     // shifted on the fall
            if (sel[0]) n1++;
            if (sel[1]) n2++;
            if (joypad1_data !== pad_bit(j1, n1))
                note_mismatch("joypad1_data", joypad1_data, pad_bit(j1, n1));
            if (joypad2_data !== pad_bit(j2, n2))
                note_mismatch("joypad2_data", joypad2_data, pad_bit(j2, n2));
        end
        end_test("joypad");

        $display("tests run %0d, failed checks %0d", tests, errors);
        if (errors == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+sim
design/nes_bus_pkg.sv
design/nes_console_pkg.sv
design/rv_half_if.sv
design/rv_half_seq.sv
design/rv_half_port.sv
design/cart_load_ctrl.sv
design/joypad_serial.sv
design/nes_glue_top.sv
sim/nes_glue_tb.sv

// ==== Bender.yml ====
package:
  name: nes_glue

sources:
  - files:
      - design/nes_bus_pkg.sv
      - design/nes_console_pkg.sv
      - design/rv_half_if.sv
      - design/rv_half_seq.sv
      - design/rv_half_port.sv
      - design/cart_load_ctrl.sv
      - design/joypad_serial.sv
      - design/nes_glue_top.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/nes_glue_tb.sv
